/* verilog/ctrl_settings.svh */
`ifndef CTRL_SETTINGS_SVH
`define CTRL_SETTINGS_SVH

// Instruction field and step counter widths
`define OPCODE_W 6
`define STEP_W 2

// Cycles spent in each phase
`define FETCH_STEPS 4
`define DECODE_STEPS 3
`define EXEC_STEPS 3

// Kept instruction codes
`define OPCODE_RTYPE 6'b000000
`define FUNCT_ADD 6'b100000
`define FUNCT_SUB 6'b100010
`define FUNCT_AND 6'b100100

// ALU source A mux
`define SEL_SRCA_PC 2'b00
`define SEL_SRCA_REGA 2'b10

// ALU source B mux
`define SEL_SRCB_REGB 3'b000
`define SEL_SRCB_FOUR 3'b001
`define SEL_SRCB_OFFSET 3'b010

// PC source mux
`define SEL_PC_ALU 3'b010
`define SEL_PC_EXCEPT 3'b011

// Register file write port muxes
`define SEL_DST_RD 2'b01
`define SEL_MEM_ALUOUT 3'b011

// Exception cause codes
`define CAUSE_OPCODE 2'b00
`define CAUSE_OVERFLOW 2'b01

`endif

/* verilog/ctrlPkg.sv */
package ctrlPkg;

    // Sequencer phases
    typedef enum logic [2:0] {
        resetPhase    = 3'd0,
        fetchPhase    = 3'd1,
        decodePhase   = 3'd2,
        execPhase     = 3'd3,
        overflowPhase = 3'd4,
        unknownPhase  = 3'd5
    } phaseT;

    // Decoded instruction class
    typedef enum logic [1:0] {
        addClass     = 2'd0,
        subClass     = 2'd1,
        andClass     = 2'd2,
        unknownClass = 2'd3
    } instrClassT;

    // Encoding seen by the ALU on aluOperation
    typedef enum logic [2:0] {
        aluAdd = 3'd1,
        aluSub = 3'd2,
        aluAnd = 3'd3
    } aluOpT;

endpackage

/* verilog/phaseIf.sv */
`timescale 1ns/100ps

`include "ctrl_settings.svh"

interface phaseIf (
    input logic clk
);
    import ctrlPkg::*;

    phaseT phase;
    logic [`STEP_W-1:0] step;
    instrClassT instrClass;
    aluOpT aluOp;

    // Registered sequencer state
    modport sequencer (
        input  clk,
        output phase, step, instrClass, aluOp
    );

    modport generator (
        input clk, phase, step, instrClass, aluOp
    );

endinterface

/* verilog/instrDecoder.sv */
`timescale 1ns/100ps

`include "ctrl_settings.svh"

module instrDecoder (
    input  logic [`OPCODE_W-1:0] opcode,
    input  logic [`OPCODE_W-1:0] funct,
    output ctrlPkg::instrClassT instrClass,
    output ctrlPkg::aluOpT aluOp
);
    import ctrlPkg::*;

    // Only register-format instructions are kept
    always_comb begin
        instrClass = unknownClass;
        if (opcode == `OPCODE_RTYPE) begin
            case (funct)
                `FUNCT_ADD: begin
                    instrClass = addClass;
                end
                `FUNCT_SUB: begin
                    instrClass = subClass;
                end
                `FUNCT_AND: begin
                    instrClass = andClass;
                end
                default: begin
                    instrClass = unknownClass;
                end
            endcase
        end
    end

    // Unknown class never reaches execute
    always_comb begin
        case (instrClass)
            subClass: begin
                aluOp = aluSub;
            end
            andClass: begin
                aluOp = aluAnd;
            end
            default: begin
                aluOp = aluAdd;
            end
        endcase
    end

endmodule

/* verilog/phaseSequencer.sv */
`timescale 1ns/100ps

`include "ctrl_settings.svh"

module phaseSequencer (
    input  logic clk,
    input  logic reset,
    input  ctrlPkg::instrClassT instrClass,
    input  ctrlPkg::aluOpT aluOp,
    input  logic overflow,
    output logic resetOut,
    phaseIf.sequencer seq
);
    import ctrlPkg::*;

    localparam logic [`STEP_W-1:0] FETCH_LAST = `STEP_W'(`FETCH_STEPS - 1);
    localparam logic [`STEP_W-1:0] DECODE_LAST = `STEP_W'(`DECODE_STEPS - 1);
    localparam logic [`STEP_W-1:0] EXEC_LAST = `STEP_W'(`EXEC_STEPS - 1);
    // Execute step where the ALU flags are valid
    localparam logic [`STEP_W-1:0] OVF_STEP = `STEP_W'(1);

    phaseT phaseQ;
    logic [`STEP_W-1:0] stepQ;
    instrClassT classQ;
    aluOpT opQ;
    logic overflowTrap;
    logic [`STEP_W:0] stepBound;

    // AND ignores the overflow flag
    assign overflowTrap = overflow && (classQ == addClass || classQ == subClass);

    always_ff @(posedge clk) begin
        if (reset) begin
            phaseQ <= resetPhase;
            stepQ <= '0;
        end else begin
            case (phaseQ)
                fetchPhase: begin
                    if (stepQ == FETCH_LAST) begin
                        phaseQ <= decodePhase;
                        stepQ <= '0;
                    end else begin
                        stepQ <= stepQ + 1'b1;
                    end
                end
                decodePhase: begin
                    if (stepQ == DECODE_LAST) begin
                        phaseQ <= (instrClass == unknownClass) ? unknownPhase : execPhase;
                        stepQ <= '0;
                    end else begin
                        stepQ <= stepQ + 1'b1;
                    end
                end
                execPhase: begin
                    if (stepQ == OVF_STEP && overflowTrap) begin
                        phaseQ <= overflowPhase;
                        stepQ <= '0;
                    end else if (stepQ == EXEC_LAST) begin
                        phaseQ <= fetchPhase;
                        stepQ <= '0;
                    end else begin
                        stepQ <= stepQ + 1'b1;
                    end
                end
                default: begin
                    // Reset and both traps fall through to fetch
                    phaseQ <= fetchPhase;
                    stepQ <= '0;
                end
            endcase
        end
    end

    // Instruction held for execute
    always_ff @(posedge clk) begin
        if (phaseQ == decodePhase && stepQ == DECODE_LAST) begin
            classQ <= instrClass;
            opQ <= aluOp;
        end
    end

    assign resetOut = (phaseQ == resetPhase);

    assign seq.phase = phaseQ;
    assign seq.step = stepQ;
    assign seq.instrClass = classQ;
    assign seq.aluOp = opQ;

    always_comb begin
        case (phaseQ)
            fetchPhase: begin
                stepBound = (`STEP_W+1)'(`FETCH_STEPS);
            end
            decodePhase: begin
                stepBound = (`STEP_W+1)'(`DECODE_STEPS);
            end
            execPhase: begin
                stepBound = (`STEP_W+1)'(`EXEC_STEPS);
            end
            default: begin
                stepBound = (`STEP_W+1)'(1);
            end
        endcase
    end

    stepInRange: assert property (@(posedge clk) disable iff (reset)
        {1'b0, stepQ} < stepBound);

    // Traps are single cycle and return to fetch
    trapOneCycle: assert property (@(posedge clk) disable iff (reset)
        (phaseQ == overflowPhase || phaseQ == unknownPhase) |=> phaseQ == fetchPhase);

endmodule

/* verilog/controlWordGen.sv */
`timescale 1ns/100ps

`include "ctrl_settings.svh"

module controlWordGen (
    phaseIf.generator seq,
    output logic [2:0] iorD,
    output logic [1:0] causeControl,
    output logic memWr,
    output logic irWrite,
    output logic [1:0] regDst,
    output logic [2:0] memToReg,
    output logic regWr,
    output logic writeA,
    output logic writeB,
    output logic [1:0] aluSrcA,
    output logic [2:0] aluSrcB,
    output ctrlPkg::aluOpT aluOperation,
    output logic aluOutWrite,
    output logic [2:0] pcSource,
    output logic pcWrite,
    output logic epcWrite
);
    import ctrlPkg::*;

    always_comb begin
        // Memory is always addressed by PC and never written
        iorD = 3'b000;
        memWr = 1'b0;
        causeControl = `CAUSE_OPCODE;
        irWrite = 1'b0;
        regDst = 2'b00;
        memToReg = 3'b000;
        regWr = 1'b0;
        writeA = 1'b0;
        writeB = 1'b0;
        aluSrcA = `SEL_SRCA_PC;
        aluSrcB = `SEL_SRCB_FOUR;
        aluOperation = aluAdd;
        aluOutWrite = 1'b0;
        pcSource = `SEL_PC_ALU;
        pcWrite = 1'b0;
        epcWrite = 1'b0;

        case (seq.phase)
            fetchPhase: begin
                // PC + 4 settles over the first steps
                if (seq.step == `STEP_W'(`FETCH_STEPS - 1)) begin
                    irWrite = 1'b1;
                    pcWrite = 1'b1;
                end
            end
            decodePhase: begin
                // Branch target precomputed into ALU-out
                aluSrcB = `SEL_SRCB_OFFSET;
                if (seq.step != `STEP_W'(`DECODE_STEPS - 1)) begin
                    writeA = 1'b1;
                    writeB = 1'b1;
                    aluOutWrite = 1'b1;
                end
            end
            execPhase: begin
                aluSrcA = `SEL_SRCA_REGA;
                aluSrcB = `SEL_SRCB_REGB;
                aluOperation = seq.aluOp;
                if (seq.step == '0) begin
                    aluOutWrite = 1'b1;
                end
                if (seq.step == `STEP_W'(`EXEC_STEPS - 1)) begin
                    regDst = `SEL_DST_RD;
                    memToReg = `SEL_MEM_ALUOUT;
                    regWr = (seq.instrClass != unknownClass);
                end
            end
            overflowPhase: begin
                // EPC takes PC - 4 from the ALU
                aluOperation = aluSub;
                causeControl = `CAUSE_OVERFLOW;
                pcSource = `SEL_PC_EXCEPT;
                pcWrite = 1'b1;
                epcWrite = 1'b1;
            end
            unknownPhase: begin
                aluOperation = aluSub;
                causeControl = `CAUSE_OPCODE;
                pcSource = `SEL_PC_EXCEPT;
                pcWrite = 1'b1;
                epcWrite = 1'b1;
            end
            default: begin
                // Reset phase keeps every enable low
                aluOperation = aluAdd;
            end
        endcase
    end

    // A trapped instruction must not commit its result
    noWriteOnTrap: assert property (@(posedge seq.clk) !(regWr && epcWrite));

    irLoadAdvancesPc: assert property (@(posedge seq.clk) irWrite |-> pcWrite);

endmodule

/* verilog/controlUnit.sv */
`timescale 1ns/100ps

`include "ctrl_settings.svh"

module controlUnit (
    input  logic clk,
    input  logic reset,
    input  logic [`OPCODE_W-1:0] opcode,
    input  logic [`OPCODE_W-1:0] funct,
    input  logic overflow,
    output logic [2:0] iorD,
    output logic [1:0] causeControl,
    output logic memWr,
    output logic irWrite,
    output logic [1:0] regDst,
    output logic [2:0] memToReg,
    output logic regWr,
    output logic writeA,
    output logic writeB,
    output logic [1:0] aluSrcA,
    output logic [2:0] aluSrcB,
    output ctrlPkg::aluOpT aluOperation,
    output logic aluOutWrite,
    output logic [2:0] pcSource,
    output logic pcWrite,
    output logic epcWrite,
    output logic resetOut
);
    import ctrlPkg::*;

    instrClassT decodedClass;
    aluOpT decodedOp;

    phaseIf phaseBus (
        .clk(clk)
    );

    instrDecoder decoder (
        .opcode(opcode),
        .funct(funct),
        .instrClass(decodedClass),
        .aluOp(decodedOp)
    );

    phaseSequencer sequencer (
        .clk(clk),
        .reset(reset),
        .instrClass(decodedClass),
        .aluOp(decodedOp),
        .overflow(overflow),
        .resetOut(resetOut),
        .seq(phaseBus.sequencer)
    );

    controlWordGen wordGen (
        .seq(phaseBus.generator),
        .iorD(iorD),
        .causeControl(causeControl),
        .memWr(memWr),
        .irWrite(irWrite),
        .regDst(regDst),
        .memToReg(memToReg),
        .regWr(regWr),
        .writeA(writeA),
        .writeB(writeB),
        .aluSrcA(aluSrcA),
        .aluSrcB(aluSrcB),
        .aluOperation(aluOperation),
        .aluOutWrite(aluOutWrite),
        .pcSource(pcSource),
        .pcWrite(pcWrite),
        .epcWrite(epcWrite)
    );

endmodule

/* verification/controlUnitChecks.svh */
`ifndef CONTROL_UNIT_CHECKS_SVH
`define CONTROL_UNIT_CHECKS_SVH

task automatic checkBit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
        mismatchCount = mismatchCount + 1;
        $display("MISMATCH %s: got 0x%h expected 0x%h at %0t", name, actual, expected, $time);
    end
endtask

task automatic checkCause(input string name, input logic [1:0] actual,
        input logic [1:0] expected);
    if (actual !== expected) begin
        mismatchCount = mismatchCount + 1;
        $display("MISMATCH %s: got 0x%h expected 0x%h at %0t", name, actual, expected, $time);
    end
endtask

// Mux selects are at most 3 bits wide
task automatic checkSelect(input string name, input logic [2:0] actual,
        input logic [2:0] expected);
    if (actual !== expected) begin
        mismatchCount = mismatchCount + 1;
        $display("MISMATCH %s: got 0x%h expected 0x%h at %0t", name, actual, expected, $time);
    end
endtask

task automatic checkAluOp(input string name, input aluOpT actual, input aluOpT expected);
    if (actual !== expected) begin
        mismatchCount = mismatchCount + 1;
        $display("MISMATCH %s: got 0x%h expected 0x%h at %0t", name, actual, expected, $time);
    end
endtask

task automatic checkCycles(input string name, input int actual, input int expected);
    if (actual != expected) begin
        mismatchCount = mismatchCount + 1;
        $display("MISMATCH %s: got 0x%h expected 0x%h at %0t", name, actual, expected, $time);
    end
endtask

// Fetch steps 0 to 2 compute PC + 4
task automatic checkFetchSelects();
    checkSelect("aluSrcA", {1'b0, aluSrcA}, {1'b0, `SEL_SRCA_PC});
    checkSelect("aluSrcB", aluSrcB, `SEL_SRCB_FOUR);
    checkAluOp("aluOperation", aluOperation, aluAdd);
    checkSelect("pcSource", pcSource, `SEL_PC_ALU);
endtask

// Counts falling edges until irWrite is seen
task automatic waitForIrWrite(output int cycles, output logic found);
    cycles = 0;
    found = 1'b0;
    while (!found && cycles < IR_TIMEOUT) begin
        @(negedge clk);
        cycles = cycles + 1;
        found = (irWrite === 1'b1);
    end
    if (!found) begin
        timeoutCount = timeoutCount + 1;
        $display("Timeout: irWrite did not rise within %0d cycles at %0t", IR_TIMEOUT, $time);
    end
endtask

`endif

/* verification/controlUnitTb.sv */
`timescale 1ns/100ps

`include "ctrl_settings.svh"

module controlUnitTb;
    import ctrlPkg::*;

    localparam int IR_TIMEOUT = 20;
    localparam int RANDOM_ROWS = 12;

    typedef enum logic [1:0] {
        writeBack,
        overflowTrap,
        unknownTrap
    } outcomeT;

    typedef struct packed {
        logic [`OPCODE_W-1:0] opcode;
        logic [`OPCODE_W-1:0] funct;
        logic overflow;
        aluOpT aluOp;
        outcomeT outcome;
    } rowT;

    logic clk;
    logic reset;
    logic [`OPCODE_W-1:0] opcode;
    logic [`OPCODE_W-1:0] funct;
    logic overflow;
    logic [2:0] iorD;
    logic [1:0] causeControl;
    logic memWr;
    logic irWrite;
    logic [1:0] regDst;
    logic [2:0] memToReg;
    logic regWr;
    logic writeA;
    logic writeB;
    logic [1:0] aluSrcA;
    logic [2:0] aluSrcB;
    aluOpT aluOperation;
    logic aluOutWrite;
    logic [2:0] pcSource;
    logic pcWrite;
    logic epcWrite;
    logic resetOut;

    int mismatchCount;
    int timeoutCount;
    rowT stimTable[$];

    `include "controlUnitChecks.svh"

    controlUnit DUT (
        .clk(clk),
        .reset(reset),
        .opcode(opcode),
        .funct(funct),
        .overflow(overflow),
        .iorD(iorD),
        .causeControl(causeControl),
        .memWr(memWr),
        .irWrite(irWrite),
        .regDst(regDst),
        .memToReg(memToReg),
        .regWr(regWr),
        .writeA(writeA),
        .writeB(writeB),
        .aluSrcA(aluSrcA),
        .aluSrcB(aluSrcB),
        .aluOperation(aluOperation),
        .aluOutWrite(aluOutWrite),
        .pcSource(pcSource),
        .pcWrite(pcWrite),
        .epcWrite(epcWrite),
        .resetOut(resetOut)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic addRow(input logic [`OPCODE_W-1:0] opc, input logic [`OPCODE_W-1:0] fn,
            input logic ovf, input aluOpT op, input outcomeT outcome);
        rowT row;
        row.opcode = opc;
        row.funct = fn;
        row.overflow = ovf;
        row.aluOp = op;
        row.outcome = outcome;
        stimTable.push_back(row);
    endtask

    // Expected result of a random pair, from the kept instruction set
    task automatic addPredictedRow(input logic [`OPCODE_W-1:0] opc,
            input logic [`OPCODE_W-1:0] fn, input logic ovf);
        if (opc == `OPCODE_RTYPE && fn == `FUNCT_ADD) begin
            if (ovf) begin
                addRow(opc, fn, ovf, aluAdd, overflowTrap);
            end else begin
                addRow(opc, fn, ovf, aluAdd, writeBack);
            end
        end else if (opc == `OPCODE_RTYPE && fn == `FUNCT_SUB) begin
            if (ovf) begin
                addRow(opc, fn, ovf, aluSub, overflowTrap);
            end else begin
                addRow(opc, fn, ovf, aluSub, writeBack);
            end
        end else if (opc == `OPCODE_RTYPE && fn == `FUNCT_AND) begin
            addRow(opc, fn, ovf, aluAnd, writeBack);
        end else begin
            addRow(opc, fn, ovf, aluAdd, unknownTrap);
        end
    endtask

    task automatic buildTable();
        logic [`OPCODE_W-1:0] opc;
        logic [`OPCODE_W-1:0] fn;
        addRow(`OPCODE_RTYPE, `FUNCT_ADD, 1'b0, aluAdd, writeBack);
        addRow(`OPCODE_RTYPE, `FUNCT_SUB, 1'b0, aluSub, writeBack);
        addRow(`OPCODE_RTYPE, `FUNCT_AND, 1'b0, aluAnd, writeBack);
        addRow(`OPCODE_RTYPE, `FUNCT_ADD, 1'b1, aluAdd, overflowTrap);
        addRow(`OPCODE_RTYPE, `FUNCT_SUB, 1'b1, aluSub, overflowTrap);
        addRow(`OPCODE_RTYPE, `FUNCT_AND, 1'b1, aluAnd, writeBack);
        addRow(`OPCODE_RTYPE, 6'b100101, 1'b0, aluAdd, unknownTrap);
        addRow(6'b100011, `FUNCT_ADD, 1'b0, aluAdd, unknownTrap);
        addRow(6'b001000, 6'b000000, 1'b1, aluAdd, unknownTrap);
        addRow(`OPCODE_RTYPE, `FUNCT_ADD, 1'b0, aluAdd, writeBack);
        // Half the random rows keep the R-type opcode
        for (int i = 0; i < RANDOM_ROWS; i++) begin
            opc = ($urandom() % 2 == 0) ? `OPCODE_RTYPE : 6'($urandom());
            fn = 6'($urandom());
            addPredictedRow(opc, fn, 1'($urandom()));
        end
    endtask

    // Called on the irWrite cycle, checks every cycle up to the next fetch
    task automatic runRow(input rowT row);
        int interval;
        int trapStep;
        logic execute;
        opcode = row.opcode;
        funct = row.funct;
        overflow = row.overflow;
        interval = (row.outcome == unknownTrap) ? 8 : 10;
        trapStep = (row.outcome == overflowTrap) ? 6 : ((row.outcome == unknownTrap) ? 4 : -1);
        execute = (row.outcome != unknownTrap);
        for (int k = 1; k < interval; k++) begin
            @(negedge clk);
            checkBit("irWrite", irWrite, 1'b0);
            checkBit("resetOut", resetOut, 1'b0);
            checkBit("memWr", memWr, 1'b0);
            // Memory is only read at the PC
            checkSelect("iorD", iorD, 3'b000);
            checkBit("writeA", writeA, k <= 2);
            checkBit("writeB", writeB, k <= 2);
            checkBit("aluOutWrite", aluOutWrite, k <= 2 || (k == 4 && execute));
            checkBit("regWr", regWr, row.outcome == writeBack && k == 6);
            checkBit("epcWrite", epcWrite, k == trapStep);
            checkBit("pcWrite", pcWrite, k == trapStep);
            if (k == 4 && execute) begin
                checkAluOp("aluOperation", aluOperation, row.aluOp);
                checkSelect("aluSrcA", {1'b0, aluSrcA}, {1'b0, `SEL_SRCA_REGA});
                checkSelect("aluSrcB", aluSrcB, `SEL_SRCB_REGB);
            end
            if (k == 6 && row.outcome == writeBack) begin
                checkSelect("memToReg", memToReg, `SEL_MEM_ALUOUT);
                checkSelect("regDst", {1'b0, regDst}, {1'b0, `SEL_DST_RD});
            end
            if (k == trapStep) begin
                checkCause("causeControl", causeControl,
                    (row.outcome == overflowTrap) ? `CAUSE_OVERFLOW : `CAUSE_OPCODE);
                checkSelect("pcSource", pcSource, `SEL_PC_EXCEPT);
            end
            if (k >= interval - 3) begin
                checkFetchSelects();
            end
        end
    endtask

    initial begin
        int gap;
        int rowIndex;
        logic found;
        logic aborted;
        mismatchCount = 0;
        timeoutCount = 0;
        reset = 1'b1;
        opcode = `OPCODE_RTYPE;
        funct = '0;
        overflow = 1'b0;
        aborted = 1'b0;
        void'($urandom(75));
        buildTable();

        repeat (8) begin
            @(negedge clk);
            checkBit("resetOut", resetOut, 1'b1);
            checkBit("irWrite", irWrite, 1'b0);
            checkBit("pcWrite", pcWrite, 1'b0);
            checkBit("regWr", regWr, 1'b0);
            checkBit("epcWrite", epcWrite, 1'b0);
            checkBit("writeA", writeA, 1'b0);
            checkBit("writeB", writeB, 1'b0);
            checkBit("aluOutWrite", aluOutWrite, 1'b0);
            checkBit("memWr", memWr, 1'b0);
        end
        reset = 1'b0;

        // First fetch steps before the IR load
        repeat (3) begin
            @(negedge clk);
            checkBit("resetOut", resetOut, 1'b0);
            checkBit("irWrite", irWrite, 1'b0);
            checkBit("pcWrite", pcWrite, 1'b0);
            checkFetchSelects();
        end

        rowIndex = 0;
        while (!aborted && rowIndex < stimTable.size()) begin
            waitForIrWrite(gap, found);
            if (!found) begin
                aborted = 1'b1;
            end else begin
                checkCycles("irWrite delay", gap, 1);
                checkBit("pcWrite", pcWrite, 1'b1);
                runRow(stimTable[rowIndex]);
                rowIndex = rowIndex + 1;
            end
        end
        if (!aborted) begin
            waitForIrWrite(gap, found);
            if (found) begin
                checkCycles("irWrite delay", gap, 1);
            end
        end

        $display("Errors: %0d mismatches, %0d timeouts over %0d rows",
            mismatchCount, timeoutCount, rowIndex);
        if (mismatchCount == 0 && timeoutCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* multicycleCtrl.f */
+incdir+verilog
+incdir+verification
verilog/ctrlPkg.sv
verilog/phaseIf.sv
verilog/instrDecoder.sv
verilog/phaseSequencer.sv
verilog/controlWordGen.sv
verilog/controlUnit.sv
verification/controlUnitTb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=controlUnitSim
LOG=sim.log

verilator --binary --timing --assert \
    -f multicycleCtrl.f \
    --top-module controlUnitTb \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" "$LOG"; then
    exit 1
fi
exit 0
